// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Default address width of the core.
    parameter int XLEN_DEFAULT = 64;

    typedef logic [63:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [31:0] mem_word_t;

    // Why an instruction was fetched.
    typedef enum logic [1:0] {
        IF_PREFETCH   = 2'b00,
        IF_PREDICT    = 2'b01,
        IF_MISPREDICT = 2'b10,
        IF_FENCE_I    = 2'b11
    } if_reason_e;

    parameter logic [3:0] EXC_CAUSE_INSTR_PAGE_FAULT = 4'd12;

    typedef struct packed {
        logic [3:0] cause;
        addr_t      tval;
    } fetch_exc_t;

    // Instruction handed to decode.
    typedef struct packed {
        addr_t      pc;
        if_reason_e if_reason;
        instr_t     instr_word;
        logic       ex_valid;
        fetch_exc_t exception;
    } fetched_instr_t;

    // Fetcher to aligner request.
    typedef struct packed {
        addr_t      pc;
        if_reason_e reason;
    } align_req_t;

    // Aligner answer. fault_plus2 marks a fault in the upper half only.
    typedef struct packed {
        instr_t instr;
        logic   fault;
        logic   fault_plus2;
    } align_resp_t;

endpackage

`default_nettype wire

// ==== src/static_branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module static_branch_predictor #(
    parameter int XLEN        = fetch_pkg::XLEN_DEFAULT,
    parameter int BRANCH_PRED = 1
) (
    input  fetch_pkg::addr_t  i_pc,
    input  fetch_pkg::instr_t i_instr,
    output logic              o_taken,
    output fetch_pkg::addr_t  o_target
);

    logic            is_branch;
    logic            is_jal;
    logic            is_c_branch;
    logic            is_c_j;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] cb_imm;
    logic [XLEN-1:0] cj_imm;
    logic            taken;
    logic [XLEN-1:0] offset;

    // Control-transfer forms.
    assign is_branch   = (i_instr[6:0] == 7'b1100011);
    assign is_jal      = (i_instr[6:0] == 7'b1101111);
    assign is_c_branch = (i_instr[1:0] == 2'b01) && (i_instr[15:14] == 2'b11);
    assign is_c_j      = (i_instr[1:0] == 2'b01) && (i_instr[15:13] == 3'b101);

    // Sign-extended immediates.
    assign b_imm = {{(XLEN-13){i_instr[31]}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};
    assign j_imm = {{(XLEN-21){i_instr[31]}}, i_instr[31], i_instr[19:12],
                    i_instr[20], i_instr[30:21], 1'b0};
    assign cb_imm = {{(XLEN-9){i_instr[12]}}, i_instr[12], i_instr[6:5],
                     i_instr[2], i_instr[11:10], i_instr[4:3], 1'b0};
    assign cj_imm = {{(XLEN-12){i_instr[12]}}, i_instr[12], i_instr[8],
                     i_instr[10:9], i_instr[6], i_instr[7], i_instr[2],
                     i_instr[11], i_instr[5:3], 1'b0};

    // Backward conditional branches are taken, jumps always.
    always_comb begin
        taken  = 1'b0;
        offset = '0;
        if (is_branch) begin
            taken  = i_instr[31];
            offset = b_imm;
        end else if (is_jal) begin
            taken  = 1'b1;
            offset = j_imm;
        end else if (is_c_branch) begin
            taken  = i_instr[12];
            offset = cb_imm;
        end else if (is_c_j) begin
            taken  = 1'b1;
            offset = cj_imm;
        end
    end

    assign o_taken  = (BRANCH_PRED != 0) && taken;
    assign o_target = i_pc + offset;

endmodule

`default_nettype wire

// ==== src/fetch_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_aligner #(
    parameter int XLEN = fetch_pkg::XLEN_DEFAULT
) (
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   i_req_valid,
    input  fetch_pkg::align_req_t  i_req,

    output logic                   o_resp_valid,
    output fetch_pkg::align_resp_t o_resp,

    output logic                   o_mem_req,
    output fetch_pkg::addr_t       o_mem_addr,
    input  fetch_pkg::mem_word_t   i_mem_rdata,
    input  logic                   i_mem_fault
);

    logic            mem_req_q;
    // Read data is returned by memory in this cycle.
    logic            rd_outstanding_q;
    // Waiting on the second word of a spanning instruction.
    logic            second_q;

    logic [XLEN-1:0] word_addr_q;
    logic            half_sel_q;
    logic [15:0]     hold_half_q;
    logic            hold_fault_q;

    logic            need_second;

    // Upper halfword starts a 32-bit instruction.
    assign need_second = rd_outstanding_q && !second_q && half_sel_q &&
                         (i_mem_rdata[17:16] == 2'b11);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            mem_req_q        <= 1'b0;
            rd_outstanding_q <= 1'b0;
            second_q         <= 1'b0;
        end else begin
            mem_req_q        <= i_req_valid || need_second;
            rd_outstanding_q <= mem_req_q;
            if (need_second) begin
                second_q <= 1'b1;
            end else if (o_resp_valid) begin
                second_q <= 1'b0;
            end
        end
    end

    // Word address and the held first halfword.
    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            word_addr_q <= {i_req.pc[XLEN-1:2], 2'b00};
            half_sel_q  <= i_req.pc[1];
        end else if (need_second) begin
            word_addr_q <= word_addr_q + XLEN'(4);
        end
        if (need_second) begin
            hold_half_q  <= i_mem_rdata[31:16];
            hold_fault_q <= i_mem_fault;
        end
    end

    assign o_mem_req  = mem_req_q;
    assign o_mem_addr = word_addr_q;

    assign o_resp_valid = rd_outstanding_q && !need_second;

    always_comb begin
        o_resp.fault_plus2 = 1'b0;
        if (second_q) begin
            // Spanning instruction. The low half came from the previous word.
            o_resp.instr       = {i_mem_rdata[15:0], hold_half_q};
            o_resp.fault       = hold_fault_q;
            o_resp.fault_plus2 = !hold_fault_q && i_mem_fault;
        end else if (half_sel_q) begin
            // Compressed in the upper half; the next word is not read.
            o_resp.instr = {16'h0000, i_mem_rdata[31:16]};
            o_resp.fault = i_mem_fault;
        end else begin
            o_resp.instr = i_mem_rdata;
            o_resp.fault = i_mem_fault;
        end
    end

endmodule

`default_nettype wire

// ==== src/instr_fetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_fetcher #(
    parameter int XLEN        = fetch_pkg::XLEN_DEFAULT,
    parameter int BRANCH_PRED = 1
) (
    input  logic                      clk,
    input  logic                      resetn,

    input  logic                      i_redirect_valid,
    input  fetch_pkg::addr_t          i_redirect_pc,
    input  fetch_pkg::if_reason_e     i_redirect_reason,

    output logic                      o_req_valid,
    output fetch_pkg::align_req_t     o_req,
    input  logic                      i_resp_valid,
    input  fetch_pkg::align_resp_t    i_resp,

    output logic                      o_valid,
    input  logic                      i_ready,
    output fetch_pkg::fetched_instr_t o_fetched_instr
);

    logic                  redir_valid_q;
    logic [XLEN-1:0]       redir_pc_q;
    fetch_pkg::if_reason_e redir_reason_q;

    logic [XLEN-1:0]       pc_q;
    fetch_pkg::if_reason_e reason_q;

    logic                  latched_q;
    fetch_pkg::instr_t     latch_instr_q;
    logic                  latch_fault_q;
    logic                  latch_fault_plus2_q;

    logic                  xfer;
    fetch_pkg::instr_t     cur_instr;
    logic                  cur_fault;
    logic                  cur_fault_plus2;
    logic                  pred_taken;
    logic [XLEN-1:0]       pred_target;
    logic [XLEN-1:0]       npc_word;
    logic [XLEN-1:0]       npc_seq;
    logic [XLEN-1:0]       pc_next;
    fetch_pkg::if_reason_e reason_next;

    assign xfer = o_valid && i_ready;

    // Redirect register. Its reset value restarts fetching at PC 0.
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            redir_valid_q  <= 1'b1;
            redir_pc_q     <= '0;
            redir_reason_q <= fetch_pkg::IF_FENCE_I;
        end else begin
            if (xfer) begin
                redir_valid_q <= 1'b0;
            end
            if (i_redirect_valid) begin
                redir_valid_q  <= 1'b1;
                redir_pc_q     <= i_redirect_pc;
                redir_reason_q <= i_redirect_reason;
            end
        end
    end

    // Skid latch. Its reset value is the kick-start token.
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            latched_q           <= 1'b1;
            latch_instr_q       <= '0;
            latch_fault_q       <= 1'b0;
            latch_fault_plus2_q <= 1'b0;
        end else if (i_ready) begin
            latched_q <= 1'b0;
        end else if (i_resp_valid) begin
            latched_q           <= 1'b1;
            latch_instr_q       <= i_resp.instr;
            latch_fault_q       <= i_resp.fault;
            latch_fault_plus2_q <= i_resp.fault_plus2;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pc_q     <= '0;
            reason_q <= fetch_pkg::IF_PREFETCH;
        end else if (xfer) begin
            pc_q     <= pc_next;
            reason_q <= reason_next;
        end
    end

    assign o_valid         = i_resp_valid || latched_q;
    assign cur_instr       = latched_q ? latch_instr_q : i_resp.instr;
    assign cur_fault       = latched_q ? latch_fault_q : i_resp.fault;
    assign cur_fault_plus2 = latched_q ? latch_fault_plus2_q : i_resp.fault_plus2;

    static_branch_predictor #(
        .XLEN        (XLEN),
        .BRANCH_PRED (BRANCH_PRED)
    ) u_predictor (
        .i_pc     (pc_q),
        .i_instr  (cur_instr),
        .o_taken  (pred_taken),
        .o_target (pred_target)
    );

    // Word increment keeps the adder off the instruction length decode.
    assign npc_word = {pc_q[XLEN-1:2], 2'b00} + XLEN'(4);

    always_comb begin
        npc_seq = npc_word;
        if (cur_instr[1:0] == 2'b11) begin
            npc_seq[1] = pc_q[1];
        end else if (!pc_q[1]) begin
            npc_seq = {pc_q[XLEN-1:2], 2'b10};
        end
    end

    assign pc_next = redir_valid_q ? {redir_pc_q[XLEN-1:1], 1'b0} :
                     pred_taken    ? pred_target : npc_seq;
    assign reason_next = redir_valid_q ? redir_reason_q :
                         pred_taken    ? fetch_pkg::IF_PREDICT : fetch_pkg::IF_PREFETCH;

    assign o_req_valid = xfer;
    assign o_req.pc     = pc_next;
    assign o_req.reason = reason_next;

    assign o_fetched_instr.pc               = pc_q;
    assign o_fetched_instr.if_reason        = reason_q;
    assign o_fetched_instr.instr_word       = cur_instr;
    assign o_fetched_instr.ex_valid         = cur_fault || cur_fault_plus2;
    assign o_fetched_instr.exception.cause  = fetch_pkg::EXC_CAUSE_INSTR_PAGE_FAULT;
    // Upper-half fault reports the address of the second word.
    assign o_fetched_instr.exception.tval   = cur_fault_plus2 ? npc_word : pc_q;

endmodule

`default_nettype wire

// ==== src/fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend #(
    parameter int XLEN        = fetch_pkg::XLEN_DEFAULT,
    parameter int BRANCH_PRED = 1
) (
    input  logic                      clk,
    input  logic                      resetn,

    input  logic                      i_redirect_valid,
    input  fetch_pkg::addr_t          i_redirect_pc,
    input  fetch_pkg::if_reason_e     i_redirect_reason,

    output logic                      o_valid,
    input  logic                      i_ready,
    output fetch_pkg::fetched_instr_t o_fetched_instr,

    output logic                      o_mem_req,
    output fetch_pkg::addr_t          o_mem_addr,
    input  fetch_pkg::mem_word_t      i_mem_rdata,
    input  logic                      i_mem_fault
);

    logic                   req_valid;
    fetch_pkg::align_req_t  req;
    logic                   resp_valid;
    fetch_pkg::align_resp_t resp;

    instr_fetcher #(
        .XLEN        (XLEN),
        .BRANCH_PRED (BRANCH_PRED)
    ) u_fetcher (
        .clk               (clk),
        .resetn            (resetn),
        .i_redirect_valid  (i_redirect_valid),
        .i_redirect_pc     (i_redirect_pc),
        .i_redirect_reason (i_redirect_reason),
        .o_req_valid       (req_valid),
        .o_req             (req),
        .i_resp_valid      (resp_valid),
        .i_resp            (resp),
        .o_valid           (o_valid),
        .i_ready           (i_ready),
        .o_fetched_instr   (o_fetched_instr)
    );

    fetch_aligner #(
        .XLEN (XLEN)
    ) u_aligner (
        .clk          (clk),
        .resetn       (resetn),
        .i_req_valid  (req_valid),
        .i_req        (req),
        .o_resp_valid (resp_valid),
        .o_resp       (resp),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_rdata  (i_mem_rdata),
        .i_mem_fault  (i_mem_fault)
    );

endmodule

`default_nettype wire

// ==== dv/fetch_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      i_valid,
    input  logic                      i_ready,
    input  fetch_pkg::fetched_instr_t i_fetched,
    input  logic                      i_mem_req,
    input  fetch_pkg::addr_t          i_mem_addr,
    input  logic                      i_redirect_valid,
    input  fetch_pkg::addr_t          i_redirect_pc,
    input  fetch_pkg::if_reason_e     i_redirect_reason,
    input  int                        i_test_idx,
    output int                        o_xfers,
    output int                        o_errors
);

    logic [32:0]               mem [logic [63:0]];
    string                     names [16];
    logic [63:0]               exp_pc;
    fetch_pkg::if_reason_e     exp_reason;
    logic                      first;
    logic                      pend;
    logic [63:0]               pend_pc;
    fetch_pkg::if_reason_e     pend_reason;
    logic                      held_q;
    fetch_pkg::fetched_instr_t held_val;
    logic [63:0]               exp_addr;
    int                        reads_left;

    // Own copy of the memory image and the test names.
    initial begin
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [63:0] a;
        logic [63:0] d;
        logic [63:0] f;
        logic [63:0] r;
        n  = 0;
        fd = $fopen("dv/fetch_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                void'($fgets(line, fd));
                if ($sscanf(line, "M %h %h %h", a, d, f) == 3) begin
                    mem[a] = {f[0], d[31:0]};
                end else if ($sscanf(line, "T %s %h", name, r) == 2 && n < 16) begin
                    names[n] = name;
                    n++;
                end
            end
            $fclose(fd);
        end
    end

    function automatic logic [32:0] read_word(input logic [63:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {1'b0, 32'h0000_0013};
    endfunction

    // Static prediction from the RISC-V immediate layouts; bit 64 is the taken flag.
    function automatic logic [64:0] predict(input logic [63:0] pc, input logic [31:0] ins);
        logic        tk;
        logic [63:0] off;
        tk  = 1'b0;
        off = '0;
        if (ins[6:0] == 7'b1100011) begin
            tk  = ins[31];
            off = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end else if (ins[6:0] == 7'b1101111) begin
            tk  = 1'b1;
            off = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end else if (ins[1:0] == 2'b01 && ins[15:14] == 2'b11) begin
            tk  = ins[12];
            off = {{55{ins[12]}}, ins[12], ins[6:5], ins[2], ins[11:10], ins[4:3], 1'b0};
        end else if (ins[1:0] == 2'b01 && ins[15:13] == 3'b101) begin
            tk  = 1'b1;
            off = {{52{ins[12]}}, ins[12], ins[8], ins[10:9], ins[6], ins[7], ins[2],
                   ins[11], ins[5:3], 1'b0};
        end
        return {tk, pc + off};
    endfunction

    task automatic check_field(input string field, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED test %s %s: expected %h, actual %h",
                     names[i_test_idx], field, exp, act);
            o_errors++;
        end
    endtask

    task automatic check_transfer();
        logic [32:0] w0;
        logic [32:0] w1;
        logic [31:0] ins;
        logic        ex;
        logic [63:0] tval;
        logic [64:0] pr;
        if (reads_left != 0) begin
            $display("test %s: instruction delivered before its memory reads were issued",
                     names[i_test_idx]);
            o_errors++;
        end
        w0   = read_word({exp_pc[63:2], 2'b00});
        w1   = read_word({exp_pc[63:2], 2'b00} + 64'd4);
        tval = exp_pc;
        if (first) begin
            ins = '0;
            ex  = 1'b0;
        end else if (!exp_pc[1]) begin
            ins = w0[31:0];
            ex  = w0[32];
        end else if (w0[17:16] != 2'b11) begin
            ins = {16'h0000, w0[31:16]};
            ex  = w0[32];
        end else begin
            // Spanning instruction.
            ins = {w1[15:0], w0[31:16]};
            ex  = w0[32] || w1[32];
            if (!w0[32] && w1[32]) begin
                tval = {exp_pc[63:2], 2'b00} + 64'd4;
            end
        end
        check_field("pc", exp_pc, i_fetched.pc);
        check_field("reason", 64'(exp_reason), 64'(i_fetched.if_reason));
        check_field("instr", 64'(ins), 64'(i_fetched.instr_word));
        check_field("ex_valid", 64'(ex), 64'(i_fetched.ex_valid));
        if (ex) begin
            check_field("cause", 64'd12, 64'(i_fetched.exception.cause));
            check_field("tval", tval, i_fetched.exception.tval);
        end
        // Next expected PC.
        pr    = predict(exp_pc, ins);
        first = 1'b0;
        if (pend) begin
            exp_pc     = {pend_pc[63:1], 1'b0};
            exp_reason = pend_reason;
            pend       = 1'b0;
        end else if (pr[64]) begin
            exp_pc     = pr[63:0];
            exp_reason = fetch_pkg::IF_PREDICT;
        end else begin
            exp_pc     = exp_pc + ((ins[1:0] == 2'b11) ? 64'd4 : 64'd2);
            exp_reason = fetch_pkg::IF_PREFETCH;
        end
        // Word reads that fetching the next instruction needs.
        w0         = read_word({exp_pc[63:2], 2'b00});
        exp_addr   = {exp_pc[63:2], 2'b00};
        reads_left = (exp_pc[1] && w0[17:16] == 2'b11) ? 2 : 1;
        o_xfers++;
    endtask

    // Sampled at the falling edge, where all DUT outputs are settled.
    always @(negedge clk) begin
        if (!resetn) begin
            exp_pc      = '0;
            exp_reason  = fetch_pkg::IF_PREFETCH;
            first       = 1'b1;
            pend        = 1'b1;
            pend_pc     = '0;
            pend_reason = fetch_pkg::IF_FENCE_I;
            held_q      = 1'b0;
            exp_addr    = '0;
            reads_left  = 0;
            o_xfers     = 0;
            o_errors    = 0;
        end else begin
            if (i_mem_req) begin
                if (reads_left == 0) begin
                    $display("test %s: memory read issued with no fetch outstanding",
                             names[i_test_idx]);
                    o_errors++;
                end else begin
                    check_field("mem_addr", exp_addr, i_mem_addr);
                    exp_addr = exp_addr + 64'd4;
                    reads_left--;
                end
            end
            if (held_q && (!i_valid || i_fetched !== held_val)) begin
                $display("test %s: held instruction changed while decode stalled",
                         names[i_test_idx]);
                o_errors++;
            end
            if (i_valid && i_ready) begin
                check_transfer();
            end
            held_q   = i_valid && !i_ready;
            held_val = i_fetched;
            if (i_redirect_valid) begin
                pend        = 1'b1;
                pend_pc     = i_redirect_pc;
                pend_reason = i_redirect_reason;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

    localparam int MAX_TESTS  = 16;
    localparam int WAIT_LIMIT = 200;

    logic                      clk;
    logic                      resetn;
    logic                      i_redirect_valid;
    fetch_pkg::addr_t          i_redirect_pc;
    fetch_pkg::if_reason_e     i_redirect_reason;
    logic                      o_valid;
    logic                      i_ready;
    fetch_pkg::fetched_instr_t o_fetched_instr;
    logic                      o_mem_req;
    fetch_pkg::addr_t          o_mem_addr;
    fetch_pkg::mem_word_t      i_mem_rdata;
    logic                      i_mem_fault;

    logic [32:0] mem [logic [63:0]];
    string       test_name [MAX_TESTS];
    logic        test_redir [MAX_TESTS];
    logic [63:0] test_pc [MAX_TESTS];
    int          test_count [MAX_TESTS];
    logic        test_stall [MAX_TESTS];
    int          num_tests;
    int          test_idx;
    logic        load_failed;
    logic        stall_en;
    logic [15:0] lfsr;
    logic        req_seen;
    logic [63:0] req_addr;
    int          xfers;
    int          errors;

    fetch_frontend dut (
        .clk               (clk),
        .resetn            (resetn),
        .i_redirect_valid  (i_redirect_valid),
        .i_redirect_pc     (i_redirect_pc),
        .i_redirect_reason (i_redirect_reason),
        .o_valid           (o_valid),
        .i_ready           (i_ready),
        .o_fetched_instr   (o_fetched_instr),
        .o_mem_req         (o_mem_req),
        .o_mem_addr        (o_mem_addr),
        .i_mem_rdata       (i_mem_rdata),
        .i_mem_fault       (i_mem_fault)
    );

    fetch_checker u_checker (
        .clk               (clk),
        .resetn            (resetn),
        .i_valid           (o_valid),
        .i_ready           (i_ready),
        .i_fetched         (o_fetched_instr),
        .i_mem_req         (o_mem_req),
        .i_mem_addr        (o_mem_addr),
        .i_redirect_valid  (i_redirect_valid),
        .i_redirect_pc     (i_redirect_pc),
        .i_redirect_reason (i_redirect_reason),
        .i_test_idx        (test_idx),
        .o_xfers           (xfers),
        .o_errors          (errors)
    );

    always #2 clk = ~clk;

    // Memory answers one cycle after the strobe.
    always @(negedge clk) begin
        req_seen = o_mem_req;
        req_addr = o_mem_addr;
    end

    always @(posedge clk) begin
        #0.5;
        if (req_seen) begin
            if (mem.exists(req_addr)) begin
                {i_mem_fault, i_mem_rdata} = mem[req_addr];
            end else begin
                {i_mem_fault, i_mem_rdata} = {1'b0, 32'h0000_0013};
            end
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic load_input();
        int          fd;
        string       line;
        string       name;
        logic [63:0] a;
        logic [63:0] d;
        logic [63:0] f;
        logic [63:0] r;
        logic [63:0] st;
        int          cnt;
        fd = $fopen("dv/fetch_input.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/fetch_input.txt");
            load_failed = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                void'($fgets(line, fd));
                if ($sscanf(line, "M %h %h %h", a, d, f) == 3) begin
                    mem[a] = {f[0], d[31:0]};
                end else if ($sscanf(line, "T %s %h %h %d %h", name, r, a, cnt, st) == 5
                             && num_tests < MAX_TESTS) begin
                    test_name[num_tests]  = name;
                    test_redir[num_tests] = r[0];
                    test_pc[num_tests]    = a;
                    test_count[num_tests] = cnt;
                    test_stall[num_tests] = st[0];
                    num_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_cycle(input logic redir, input logic [63:0] pc);
        @(posedge clk);
        #0.5;
        if (stall_en) begin
            lfsr    = lfsr_step(lfsr);
            i_ready = lfsr[0];
        end else begin
            i_ready = 1'b1;
        end
        i_redirect_valid  = redir;
        i_redirect_pc     = pc;
        i_redirect_reason = fetch_pkg::IF_MISPREDICT;
    endtask

    initial begin
        int   passed;
        int   failed;
        int   cycles;
        int   target;
        int   start_err;
        logic timed_out;
        clk               = 1'b0;
        resetn            = 1'b0;
        i_redirect_valid  = 1'b0;
        i_redirect_pc     = '0;
        i_redirect_reason = fetch_pkg::IF_PREFETCH;
        i_ready           = 1'b0;
        i_mem_rdata       = '0;
        i_mem_fault       = 1'b0;
        req_seen          = 1'b0;
        req_addr          = '0;
        stall_en          = 1'b0;
        lfsr              = 16'd11242;
        num_tests         = 0;
        test_idx          = 0;
        load_failed       = 1'b0;
        passed            = 0;
        failed            = 0;
        timed_out         = 1'b0;
        load_input();
        repeat (8) @(posedge clk);
        #0.5;
        resetn = 1'b1;

        for (test_idx = 0; test_idx < num_tests && !timed_out; test_idx++) begin
            stall_en  = test_stall[test_idx];
            target    = xfers + test_count[test_idx];
            start_err = errors;
            drive_cycle(test_redir[test_idx], test_pc[test_idx]);
            cycles = 1;
            while (xfers < target && cycles < WAIT_LIMIT) begin
                drive_cycle(1'b0, '0);
                cycles++;
            end
            if (xfers < target) begin
                $display("test %s: timed out, %0d of %0d instructions accepted in %0d cycles",
                         test_name[test_idx], xfers - (target - test_count[test_idx]),
                         test_count[test_idx], WAIT_LIMIT);
                timed_out = 1'b1;
                failed++;
            end else if (errors != start_err) begin
                $display("test %s: failed", test_name[test_idx]);
                failed++;
            end else begin
                $display("test %s: passed", test_name[test_idx]);
                passed++;
            end
        end

        $display("tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0 && !timed_out && !load_failed && num_tests > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/fetch_pkg.sv
src/static_branch_predictor.sv
src/fetch_aligner.sv
src/instr_fetcher.sv
src/fetch_frontend.sv
dv/fetch_checker.sv
dv/tb_fetch_frontend.sv

// ==== Makefile ====
SIM_LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f compile.f --top-module tb_fetch_frontend \
		-o Vtb_fetch_frontend
	./obj_dir/Vtb_fetch_frontend | tee $(SIM_LOG)
	grep -q "Verification passed" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

// ==== dv/fetch_input.txt ====
# M <word address hex> <data hex> <fault 0/1>
# T <name> <redirect 0/1> <start pc hex> <instructions to accept> <random stall 0/1>
M 100 80930001 0
M 104 00010010 0
M 108 00108093 0
M 200 00000463 0
M 204 0001a021 0
M 208 0100006f 0
M 20c 0001dc75 0
M 218 fe0014e3 0
M 300 00000013 1
M 304 80930001 0
M 308 00010010 1
T reset 0 0 4 0
T sequential 1 100 8 0
T predict 1 200 10 0
T odd_pc 1 101 4 0
T fault 1 300 6 0
T sequential_stall 1 100 8 1
T predict_stall 1 200 12 1
T fault_stall 1 300 6 1
